// ==== logic/memsys_pkg.sv ====
// shared memory system package with word widths, requester id and controller encodings
package memsys_pkg;

  // basic field widths
  localparam int addr_w = 16;
  localparam int data_w = 16;
  localparam int port_w = 4;

  // word address into the shared memory
  typedef logic [addr_w-1:0] addr_t;

  // one memory word
  typedef logic [data_w-1:0] data_t;

  // requester number, up to 16 requesters
  typedef logic [port_w-1:0] port_id_t;

  // controller states
  // wait idles, read and write each take one access cycle
  typedef enum logic [1:0] {
    ctlr_wait  = 2'd0,
    ctlr_read  = 2'd1,
    ctlr_write = 2'd2
  } ctlr_state_t;

  // kind of request held in the arbiter
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } op_t;

endpackage

// ==== logic/req_arbiter.sv ====
// round robin request arbiter, holds one pending request per port and grants the controller
module req_arbiter import memsys_pkg::*; #(
  parameter int num_ports = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      halt,
  input  logic [num_ports-1:0]      rd_req,
  input  logic [num_ports-1:0]      wr_req,
  input  addr_t [num_ports-1:0]     req_addr,
  input  data_t [num_ports-1:0]     req_wdata,
  input  logic                      busy,
  input  logic                      done,
  input  port_id_t                  done_port,
  output logic                      grant,
  output op_t                       grant_op,
  output port_id_t                  grant_port,
  output addr_t                     grant_addr,
  output data_t                     grant_wdata
);

  // per port pending slot
  logic [num_ports-1:0] pend;
  op_t                  pend_op    [num_ports];
  addr_t                pend_addr  [num_ports];
  data_t                pend_wdata [num_ports];

  // port that finishes this cycle
  logic [num_ports-1:0] done_hit;
  logic [num_ports-1:0] eligible;

  // rotation state
  port_id_t last_port;
  logic     grant_q;

  // selection result
  logic     found;
  port_id_t sel;

  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      done_hit[i] = done && (done_port == port_id_t'(i));
    end
  end

  // a port being answered right now must not be granted again
  assign eligible = pend & ~done_hit;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend <= '0;
    end else begin
      for (int i = 0; i < num_ports; i++) begin
        if (rd_req[i] || wr_req[i]) begin
          pend[i] <= 1'b1;
        end else if (done_hit[i]) begin
          pend[i] <= 1'b0;
        end
      end
    end
  end

  // request payload, captured with the strobe
  always_ff @(posedge clk) begin
    for (int i = 0; i < num_ports; i++) begin
      if (rd_req[i] || wr_req[i]) begin
        pend_op[i]    <= wr_req[i] ? op_write : op_read;
        pend_addr[i]  <= req_addr[i];
        pend_wdata[i] <= req_wdata[i];
      end
    end
  end

  // search starts at the port after the last grant and wraps around
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = '0;
    for (int k = 1; k <= num_ports; k++) begin
      idx = int'(last_port) + k;
      if (idx >= num_ports) idx -= num_ports;
      for (int i = 0; i < num_ports; i++) begin
        if (!found && idx == i && eligible[i]) begin
          found = 1'b1;
          sel   = port_id_t'(i);
        end
      end
    end
  end

  // controller idle, not halted, and one free cycle after each grant
  assign grant      = found && !busy && !halt && !grant_q;
  assign grant_port = sel;

  // payload mux for the selected port
  always_comb begin
    grant_op    = op_read;
    grant_addr  = '0;
    grant_wdata = '0;
    for (int i = 0; i < num_ports; i++) begin
      if (sel == port_id_t'(i)) begin
        grant_op    = pend_op[i];
        grant_addr  = pend_addr[i];
        grant_wdata = pend_wdata[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // port 0 gets first priority after reset
      last_port <= port_id_t'(num_ports - 1);
      grant_q   <= 1'b0;
    end else begin
      grant_q <= grant;
      if (grant) last_port <= sel;
    end
  end

endmodule

// ==== logic/mem_ctlr.sv ====
// shared memory controller with word array, wait/read/write FSM, range check and halt abort
module mem_ctlr import memsys_pkg::*; #(
  parameter int mem_last = 200
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     halt,
  input  logic     grant,
  input  op_t      grant_op,
  input  port_id_t grant_port,
  input  addr_t    grant_addr,
  input  data_t    grant_wdata,
  output logic     busy,
  output logic     done,
  output port_id_t done_port,
  output logic     done_err,
  output data_t    rd_data
);

  // index width for mem_last+1 words
  localparam int    idx_w     = (mem_last > 0) ? $clog2(mem_last + 1) : 1;
  localparam addr_t last_addr = addr_t'(mem_last);

  // word storage, content unknown until written
  data_t mem [0:mem_last];

  ctlr_state_t      state;
  logic [idx_w-1:0] lat_idx;
  data_t            lat_wdata;
  logic             out_of_range;

  // anything past the last valid word is rejected
  assign out_of_range = grant_addr > last_addr;

  // busy while an access is in flight
  assign busy = (state != ctlr_wait);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ctlr_wait;
      done      <= 1'b0;
      done_err  <= 1'b0;
      done_port <= '0;
    end else begin
      // done is a single cycle strobe
      done     <= 1'b0;
      done_err <= 1'b0;
      case (state)
        ctlr_wait: begin
          if (grant && !halt) begin
            done_port <= grant_port;
            if (out_of_range) begin
              // answered at once, memory untouched
              done     <= 1'b1;
              done_err <= 1'b1;
            end else if (grant_op == op_write) begin
              state <= ctlr_write;
            end else begin
              state <= ctlr_read;
            end
          end
        end
        ctlr_read, ctlr_write: begin
          state <= ctlr_wait;
          // halt drops the operation without a done
          if (!halt) done <= 1'b1;
        end
        default: begin
          state <= ctlr_wait;
        end
      endcase
    end
  end

  // latch the granted address and write word
  always_ff @(posedge clk) begin
    if (state == ctlr_wait && grant && !out_of_range) begin
      lat_idx   <= grant_addr[idx_w-1:0];
      lat_wdata <= grant_wdata;
    end
  end

  // the access itself, one cycle after the grant
  always_ff @(posedge clk) begin
    if (!halt) begin
      if (state == ctlr_write) begin
        mem[lat_idx] <= lat_wdata;
      end
      if (state == ctlr_read) begin
        rd_data <= mem[lat_idx];
      end
    end
  end

endmodule

// ==== logic/memsys_top.sv ====
// shared memory system top level joining the request arbiter and the memory controller
module memsys_top import memsys_pkg::*; #(
  parameter int num_ports = 2,
  parameter int mem_last  = 200
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  halt,
  input  logic [num_ports-1:0]  rd_req,
  input  logic [num_ports-1:0]  wr_req,
  input  addr_t [num_ports-1:0] req_addr,
  input  data_t [num_ports-1:0] req_wdata,
  output logic                  done,
  output port_id_t              done_port,
  output logic                  done_err,
  output data_t                 rd_data
);

  // arbiter to controller
  logic     grant;
  op_t      grant_op;
  port_id_t grant_port;
  addr_t    grant_addr;
  data_t    grant_wdata;

  // controller back to arbiter
  logic busy;

  req_arbiter #(
    .num_ports (num_ports)
  ) u_arbiter (
    .clk         (clk),
    .rst         (rst),
    .halt        (halt),
    .rd_req      (rd_req),
    .wr_req      (wr_req),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .busy        (busy),
    // done frees the pending slot of its port
    .done        (done),
    .done_port   (done_port),
    .grant       (grant),
    .grant_op    (grant_op),
    .grant_port  (grant_port),
    .grant_addr  (grant_addr),
    .grant_wdata (grant_wdata)
  );

  mem_ctlr #(
    .mem_last (mem_last)
  ) u_ctlr (
    .clk         (clk),
    .rst         (rst),
    .halt        (halt),
    .grant       (grant),
    .grant_op    (grant_op),
    .grant_port  (grant_port),
    .grant_addr  (grant_addr),
    .grant_wdata (grant_wdata),
    .busy        (busy),
    .done        (done),
    .done_port   (done_port),
    .done_err    (done_err),
    .rd_data     (rd_data)
  );

endmodule

// ==== dv/tb_tasks.svh ====
// testbench tasks that batch requests, strobe them and check each done against a reference memory

  // wrong value, logged with the time
  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic clear_batch();
    for (int i = 0; i < num_ports; i++) begin
      b_on[i]   = 1'b0;
      b_seen[i] = 0;
    end
  endtask

  // queue one stimulus row for the next strobe
  task automatic add_request(input logic [43:0] row);
    int p;
    p = int'(row[39:36]);
    if (p >= num_ports) begin
      $display("stimulus row names port %0d but only %0d ports exist", p, num_ports);
      errors++;
    end else begin
      b_on[p]   = 1'b1;
      // odd kinds are writes
      b_op[p]   = row[40] ? op_write : op_read;
      b_err[p]  = (row[35:32] != 4'h0);
      b_addr[p] = row[31:16];
      b_data[p] = row[15:0];
    end
  endtask

  // one done at a sample point, lat is rising edges since the strobe edge
  task automatic check_done(input int lat, input bit single);
    int p;
    int a;
    p = int'(done_port);
    if (p >= num_ports || !b_on[p]) begin
      report_error($sformatf("done for port %0d, which has no request", p));
      return;
    end
    a = int'(b_addr[p]);
    b_seen[p]++;
    if (b_seen[p] > 1) begin
      report_error($sformatf("port %0d got a second done", p));
    end
    // rotation order, only known when no halt got in the way
    if (order_q.size() > 0) begin
      if (done_port !== order_q[0]) begin
        report_error($sformatf("done for port %0d, expected port %0d next", p, order_q[0]));
      end
      void'(order_q.pop_front());
    end
    if (done_err !== b_err[p]) begin
      report_error($sformatf("port %0d done_err %b, expected %b", p, done_err, b_err[p]));
    end
    if (single && !b_err[p] && lat != idle_latency) begin
      report_error($sformatf("port %0d done after %0d cycles, expected %0d", p, lat,
                             idle_latency));
    end
    // reference model, reads compared only at written words
    if (!b_err[p] && a <= mem_last) begin
      if (b_op[p] == op_write) begin
        ref_mem[a]   = b_data[p];
        ref_valid[a] = 1'b1;
      end else if (ref_valid[a]) begin
        if (rd_data !== ref_mem[a]) begin
          report_error($sformatf("port %0d read %h at %h, model holds %h", p, rd_data,
                                 b_addr[p], ref_mem[a]));
        end
        if (rd_data !== b_data[p]) begin
          report_error($sformatf("port %0d read %h at %h, stimulus expects %h", p, rd_data,
                                 b_addr[p], b_data[p]));
        end
      end
    end
    last_port = done_port;
  endtask

  // strobe every queued request in one cycle, then collect the dones
  task automatic run_batch(input bit use_halt, input int halt_at, input int halt_len);
    int  cyc;
    int  want;
    int  got;
    int  quiet;
    int  limit;
    int  err_before;
    bit  single;
    want = 0;
    got  = 0;
    for (int i = 0; i < num_ports; i++) begin
      if (b_on[i]) want++;
    end
    single     = (want == 1) && !use_halt;
    err_before = errors;
    // expected grant order starts after the last port served
    order_q.delete();
    if (!use_halt) begin
      for (int k = 1; k <= num_ports; k++) begin
        if (b_on[(int'(last_port) + k) % num_ports]) begin
          order_q.push_back(port_id_t'((int'(last_port) + k) % num_ports));
        end
      end
    end
    // random idle gap
    repeat ($urandom_range(3, 0)) @(negedge clk);
    @(negedge clk);
    if (use_halt && halt_at == 0) halt = 1'b1;
    for (int i = 0; i < num_ports; i++) begin
      if (b_on[i]) begin
        rd_req[i]    = (b_op[i] == op_read);
        wr_req[i]    = (b_op[i] == op_write);
        req_addr[i]  = b_addr[i];
        req_wdata[i] = b_data[i];
      end
    end
    cyc   = 0;
    quiet = 0;
    limit = step_cycles + halt_at + halt_len;
    // a few quiet cycles at the end catch extra dones
    while (quiet < 4 && cyc < limit) begin
      @(negedge clk);
      cyc++;
      if (done) begin
        // halt as seen by the last rising edge
        if (halt) report_error("done while halt is high");
        check_done(cyc - 1, single);
        got++;
      end
      if (cyc == 1) begin
        rd_req = '0;
        wr_req = '0;
      end
      if (use_halt && cyc == halt_at) halt = 1'b1;
      if (use_halt && cyc == halt_at + halt_len) halt = 1'b0;
      if (got >= want && !halt) quiet++;
    end
    halt = 1'b0;
    for (int i = 0; i < num_ports; i++) begin
      if (b_on[i] && b_seen[i] == 0) begin
        $display("port %0d got no done within %0d cycles", i, limit);
        errors++;
      end
    end
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("test %0d: %0d request(s)%s, %s", tests_run, want,
             use_halt ? " under halt" : "", (errors == err_before) ? "ok" : "failed");
    clear_batch();
  endtask

// ==== dv/tb_top.sv ====
// testbench for the shared memory system, replays stimulus rows and checks every done
module tb_top
  import memsys_pkg::*;
();

  localparam int num_ports    = 2;
  localparam int mem_last     = 200;
  localparam int max_steps    = 64;
  localparam int idle_latency = 2;
  localparam int step_cycles  = 40;

  // DUT side
  logic                  clk;
  logic                  rst;
  logic                  halt;
  logic [num_ports-1:0]  rd_req;
  logic [num_ports-1:0]  wr_req;
  addr_t [num_ports-1:0] req_addr;
  data_t [num_ports-1:0] req_wdata;
  logic                  done;
  port_id_t              done_port;
  logic                  done_err;
  data_t                 rd_data;

  // rows of kind, port, err, addr, data
  logic [43:0] steps [0:max_steps-1];
  int          n_steps;
  logic        loaded = 1'b0;

  // reference memory
  data_t ref_mem   [0:mem_last];
  bit    ref_valid [0:mem_last];

  // requests strobed together
  bit       b_on   [num_ports];
  op_t      b_op   [num_ports];
  addr_t    b_addr [num_ports];
  data_t    b_data [num_ports];
  bit       b_err  [num_ports];
  int       b_seen [num_ports];
  port_id_t order_q[$];
  port_id_t last_port;

  int tests_run    = 0;
  int tests_failed = 0;
  int errors       = 0;

  `include "tb_tasks.svh"

  initial clk = 1'b0;
  always #2 clk = ~clk;

  memsys_top #(
    .num_ports (num_ports),
    .mem_last  (mem_last)
  ) uut (
    .clk       (clk),
    .rst       (rst),
    .halt      (halt),
    .rd_req    (rd_req),
    .wr_req    (wr_req),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .done      (done),
    .done_port (done_port),
    .done_err  (done_err),
    .rd_data   (rd_data)
  );

  // watchdog, scaled by the number of rows
  initial begin
    wait (loaded);
    repeat ((n_steps + 1) * step_cycles) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", (n_steps + 1) * step_cycles);
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [43:0] row;
    void'($urandom(32'h81e85cae));
    rst       = 1'b1;
    halt      = 1'b0;
    rd_req    = '0;
    wr_req    = '0;
    req_addr  = '0;
    req_wdata = '0;
    for (int i = 0; i < max_steps; i++) steps[i] = '1;
    $readmemh("dv/memsys_stim.txt", steps);
    n_steps = 0;
    while (n_steps < max_steps && steps[n_steps][43:40] != 4'hf) n_steps++;
    loaded = 1'b1;
    clear_batch();
    // port 0 first after reset
    last_port = port_id_t'(num_ports - 1);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (n_steps == 0) begin
      $display("no stimulus rows were read");
      errors++;
    end
    for (int s = 0; s < n_steps; s++) begin
      row = steps[s];
      case (row[43:40])
        4'h0, 4'h1: begin
          add_request(row);
          run_batch(1'b0, 0, 0);
        end
        4'h2, 4'h3: add_request(row);
        4'h4: run_batch(1'b0, 0, 0);
        // addr field is the halt delay, data field its length
        4'h5: run_batch(1'b1, int'(row[31:16]), int'(row[15:0]));
        default: begin
          $display("stimulus row %0d has unknown kind %h", s, row[43:40]);
          errors++;
        end
      endcase
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== dv/memsys_stim.txt ====
// one hex word per row, digits: kind, port, err, addr (4), data (4)
// kind 0 read, 1 write, 2 queued read, 3 queued write, 4 strobe queued, 5 same under halt
// kind 5 carries the halt delay in addr and the halt length in data, kind f ends the list
10000101234
00000101234
1100020ABCD
0100020ABCD
10000C85A5A
01000C85A5A
11000000001
20000101234
2100020ABCD
40000000000
30000307777
21000000001
40000000000
00000307777
20000000001
21000101234
40000000000
10100C9FFFF
01100C90000
111FFFF1111
00000C85A5A
20000101234
21000307777
50000000006
3000040BEEF
3100041CAFE
50000020005
0000040BEEF
0100041CAFE
20100D00000
21000C85A5A
40000000000
F0000000000

// ==== build.f ====
+incdir+dv
logic/memsys_pkg.sv
logic/req_arbiter.sv
logic/mem_ctlr.sv
logic/memsys_top.sv
dv/tb_top.sv

// ==== Makefile ====
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
